// File: rv_core.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_ctrl_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_lsu.sv
hdl/rv_pc_unit.sv
hdl/rv_fsm.sv
hdl/rv_core.sv
test/tb_clkgen.sv
test/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f rv_core.f --top-module tb_rv_core -o tb_rv_core

# the log decides the result, so a nonzero exit from the run is tolerated here
./obj_dir/tb_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// File: test/tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_macros.svh"

module tb_rv_core;
	localparam int PROG_N = 200;
	localparam int DUMP_BASE = 'h400;
	localparam int CYC_PER_INSTR = 24; // worst case with both stall ranges
	localparam int WATCHDOG_NS = (16 + (PROG_N + 40) * CYC_PER_INSTR) * 8;
	localparam int MEM_WORDS = 2048;

	logic clk, rstn;
	logic mem_req_valid, mem_req_ready, mem_we, mem_rsp_valid;
	logic [`RV_XLEN-1:0] mem_addr, mem_wdata, mem_rdata;
	logic [`RV_STRB_W-1:0] mem_wstrb;

	logic [31:0] mem [MEM_WORDS];
	logic [31:0] iss_mem [MEM_WORDS];
	logic [1:0] exp_kind [$]; // 0 fetch, 1 load, 2 store
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [3:0] exp_strb [$];
	logic [31:0] halt_pc;
	logic done;
	int error_count;

	logic held;
	logic [31:0] h_addr, h_wdata;
	logic h_we;
	logic [3:0] h_strb;

	tb_clkgen i_clkgen (.clk(clk), .rstn(rstn));

	rv_core i_dut (
		.clk(clk), .rstn(rstn), .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
		.mem_addr(mem_addr), .mem_we(mem_we), .mem_wstrb(mem_wstrb), .mem_wdata(mem_wdata),
		.mem_rsp_valid(mem_rsp_valid), .mem_rdata(mem_rdata)
	);

	task automatic stop_with_error(input string msg);
		error_count++;
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		stop_with_error($sformatf("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act));
	endtask

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::opc_store};
	endfunction

	function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::opc_branch};
	endfunction

	function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::opc_jal};
	endfunction

	function automatic logic [31:0] lane_mask(logic [3:0] strb);
		return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
	endfunction

	function automatic logic [31:0] alu_model(logic [2:0] f3, logic alt, logic [31:0] a,
			logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] random_alu();
		logic [2:0] f3;
		logic [6:0] f7;
		logic [11:0] imm;
		f3 = 3'($urandom % 8);
		f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2 == 1) ? 7'h20 : 7'h00;
		if ($urandom % 2 == 1)
			return enc_r(f7, 5'($urandom), 5'($urandom), f3, 5'($urandom), rv_isa_pkg::opc_op);
		imm = 12'($urandom);
		if (f3 == 3'd1 || f3 == 3'd5)
			imm = {f7, imm[4:0]}; // shift amount only
		return enc_i(imm, 5'($urandom), f3, 5'($urandom), rv_isa_pkg::opc_op_imm);
	endfunction

	task automatic build_program();
		int idx;
		int r;
		int tgt;
		int sz;
		logic [2:0] f3;
		logic [11:0] off;
		logic is_target [PROG_N + 1]; // words that some jump lands on
		logic [2:0] load_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
		logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		for (int a = 0; a < MEM_WORDS; a++)
			mem[a] = (32'(a) * 32'h9e3779b1) ^ 32'hc3a5_0f1e; // depends on every address bit
		for (int i = 0; i <= PROG_N; i++)
			is_target[i] = 1'b0;
		idx = 0;
		while (idx < PROG_N) begin
			r = int'($urandom % 16);
			tgt = idx + 1 + int'($urandom % 8); // forward only, so the program ends
			if (tgt > PROG_N)
				tgt = PROG_N;
			if (r == 5) begin
				mem[idx] = {20'($urandom), 5'($urandom),
					($urandom % 2 == 1) ? rv_isa_pkg::opc_lui : rv_isa_pkg::opc_auipc};
			end else if (r == 6) begin
				is_target[tgt] = 1'b1;
				mem[idx] = enc_b(13'((tgt - idx) * 4), 5'($urandom), 5'($urandom),
					br_f3[$urandom % 6]);
			end else if (r == 7) begin
				is_target[tgt] = 1'b1;
				mem[idx] = enc_j(21'((tgt - idx) * 4), 5'($urandom));
			end else if (r == 8 && idx + 2 <= PROG_N && !is_target[idx + 1]) begin
				if (tgt < idx + 2)
					tgt = idx + 2;
				is_target[tgt] = 1'b1;
				mem[idx] = enc_i(12'(tgt * 4), 5'd0, 3'd0, 5'd31, rv_isa_pkg::opc_op_imm);
				idx++;
				mem[idx] = enc_i(12'($urandom % 2), 5'd31, 3'd0, 5'($urandom),
					rv_isa_pkg::opc_jalr); // bit 0 of the sum is dropped
			end else if (r >= 9 && r <= 12 && idx + 2 <= PROG_N && !is_target[idx + 1]) begin
				mem[idx] = {20'h00001, 5'd30, rv_isa_pkg::opc_lui}; // x30 = data window
				idx++;
				off = 12'($urandom % 256);
				f3 = (r < 11) ? load_f3[$urandom % 5] : 3'($urandom % 3);
				sz = 1 << f3[1:0];
				if ($urandom % 4 != 0)
					off = off & ~12'(sz - 1); // most accesses aligned
				if (r < 11)
					mem[idx] = enc_i(off, 5'd30, f3, 5'($urandom), rv_isa_pkg::opc_load);
				else
					mem[idx] = enc_s(off, 5'($urandom), 5'd30, f3);
			end else if (r == 13) begin
				mem[idx] = {25'($urandom), 7'h7f}; // no such major opcode
			end else begin
				mem[idx] = random_alu();
			end
			idx++;
		end
		for (int i = 1; i < 32; i++)
			mem[PROG_N + i - 1] = enc_s(12'(DUMP_BASE + 4 * (i - 1)), 5'(i), 5'd0, 3'd2);
		mem[PROG_N + 31] = enc_j(21'd0, 5'd0);
		halt_pc = 32'((PROG_N + 31) * 4);
	endtask

	task automatic run_iss();
		logic [31:0] x [32];
		logic [31:0] pc, npc, ins, a, v, w, rs1v, rs2v, i_imm, s_imm, b_imm, data;
		logic [2:0] f3;
		logic [1:0] off;
		logic [3:0] strb;
		logic wr, cond, mis;
		int steps;
		for (int i = 0; i < 32; i++)
			x[i] = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			iss_mem[i] = mem[i];
		pc = `RV_RESET_PC;
		steps = 0;
		while (pc != halt_pc && steps < 10000) begin
			exp_kind.push_back(2'd0);
			exp_addr.push_back(pc);
			exp_data.push_back('0);
			exp_strb.push_back('0);
			ins = iss_mem[pc[12:2]];
			f3 = ins[14:12];
			rs1v = x[ins[19:15]];
			rs2v = x[ins[24:20]];
			i_imm = {{20{ins[31]}}, ins[31:20]};
			s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			b_imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			npc = pc + 4;
			wr = 1'b0;
			v = '0;
			case (ins[6:0])
				rv_isa_pkg::opc_lui: begin
					v = {ins[31:12], 12'b0};
					wr = 1'b1;
				end
				rv_isa_pkg::opc_auipc: begin
					v = pc + {ins[31:12], 12'b0};
					wr = 1'b1;
				end
				rv_isa_pkg::opc_jal: begin
					v = pc + 4;
					wr = 1'b1;
					npc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
				end
				rv_isa_pkg::opc_jalr: begin
					v = pc + 4;
					wr = 1'b1;
					npc = (rs1v + i_imm) & ~32'd1;
				end
				rv_isa_pkg::opc_branch: begin
					case (f3)
						3'd0: cond = rs1v == rs2v;
						3'd1: cond = rs1v != rs2v;
						3'd4: cond = $signed(rs1v) < $signed(rs2v);
						3'd5: cond = $signed(rs1v) >= $signed(rs2v);
						3'd6: cond = rs1v < rs2v;
						default: cond = rs1v >= rs2v;
					endcase
					if (cond)
						npc = pc + b_imm;
				end
				rv_isa_pkg::opc_load, rv_isa_pkg::opc_store: begin
					a = rs1v + ((ins[6:0] == rv_isa_pkg::opc_load) ? i_imm : s_imm);
					off = a[1:0];
					mis = (f3[1:0] == 2'd1 && off[0]) || (f3[1:0] == 2'd2 && off != 2'd0);
					if (!mis && ins[6:0] == rv_isa_pkg::opc_load) begin
						w = iss_mem[a[12:2]];
						exp_kind.push_back(2'd1);
						exp_addr.push_back({a[31:2], 2'b00});
						exp_data.push_back('0);
						exp_strb.push_back('0);
						if (f3[1:0] == 2'd0) begin
							v = (w >> ((3 - int'(off)) * 8)) & 32'hff; // lane 0 is [31:24]
							if (!f3[2])
								v = {{24{v[7]}}, v[7:0]};
						end else if (f3[1:0] == 2'd1) begin
							v = (w >> ((2 - int'(off)) * 8)) & 32'hffff;
							if (!f3[2])
								v = {{16{v[15]}}, v[15:0]};
						end else begin
							v = w;
						end
						wr = 1'b1;
					end else if (!mis) begin
						if (f3[1:0] == 2'd0) begin
							strb = 4'b0001 << (3 - int'(off));
							data = {24'b0, rs2v[7:0]} << ((3 - int'(off)) * 8);
						end else if (f3[1:0] == 2'd1) begin
							strb = 4'b0011 << (2 - int'(off));
							data = {16'b0, rs2v[15:0]} << ((2 - int'(off)) * 8);
						end else begin
							strb = 4'b1111;
							data = rs2v;
						end
						exp_kind.push_back(2'd2);
						exp_addr.push_back({a[31:2], 2'b00});
						exp_data.push_back(data);
						exp_strb.push_back(strb);
						iss_mem[a[12:2]] = (iss_mem[a[12:2]] & ~lane_mask(strb))
							| (data & lane_mask(strb));
					end
				end
				rv_isa_pkg::opc_op_imm: begin
					v = alu_model(f3, f3 == 3'd5 && ins[30], rs1v, i_imm);
					wr = 1'b1;
				end
				rv_isa_pkg::opc_op: begin
					v = alu_model(f3, ins[30], rs1v, rs2v);
					wr = 1'b1;
				end
				default: wr = 1'b0; // illegal word is skipped
			endcase
			if (wr && ins[11:7] != 5'd0)
				x[ins[11:7]] = v;
			pc = npc;
			steps++;
		end
		exp_kind.push_back(2'd0); // the halt word is fetched once before the loop repeats
		exp_addr.push_back(halt_pc);
		exp_data.push_back('0);
		exp_strb.push_back('0);
	endtask

	task automatic check_access(input logic [31:0] a, input logic we, input logic [3:0] st,
			input logic [31:0] wd);
		logic [1:0] k;
		logic [31:0] ea, ed, m;
		logic [3:0] es;
		if (exp_kind.size() == 0) begin
			assert (!we && a == halt_pc)
			else stop_with_error("request seen after the program reached its final loop");
			done = 1'b1;
			return;
		end
		k = exp_kind.pop_front();
		ea = exp_addr.pop_front();
		ed = exp_data.pop_front();
		es = exp_strb.pop_front();
		assert (we == (k == 2'd2)) else report_value("mem_we", 32'(k == 2'd2), 32'(we));
		assert (a == ea) else report_value("mem_addr", ea, a);
		if (k == 2'd2) begin
			m = lane_mask(es);
			assert (st == es) else report_value("mem_wstrb", 32'(es), 32'(st));
			assert ((wd & m) == (ed & m)) else report_value("mem_wdata", ed & m, wd & m);
			mem[a[12:2]] = (mem[a[12:2]] & ~m) | (wd & m);
		end
	endtask

	// memory model, one request at a time
	initial begin
		int d;
		logic [31:0] a, wd;
		logic we;
		logic [3:0] st;
		mem_req_ready = 1'b0;
		mem_rsp_valid = 1'b0;
		mem_rdata = '0;
		forever begin
			@(posedge clk);
			#1;
			if (rstn && mem_req_valid) begin
				d = int'($urandom % 4);
				repeat (d) begin
					@(posedge clk);
					#1;
				end
				mem_req_ready = 1'b1;
				a = mem_addr;
				we = mem_we;
				st = mem_wstrb;
				wd = mem_wdata;
				@(posedge clk);
				#1;
				mem_req_ready = 1'b0;
				check_access(a, we, st, wd);
				d = int'($urandom % 4); // response 1 to 4 cycles after the transfer
				repeat (d) begin
					@(posedge clk);
					#1;
				end
				mem_rsp_valid = 1'b1;
				mem_rdata = we ? 32'h0 : mem[a[12:2]];
				@(posedge clk);
				#1;
				mem_rsp_valid = 1'b0;
			end
		end
	end

	// request fields must hold while stalled
	always @(negedge clk) begin
		if (!rstn) begin
			assert (!mem_req_valid) else stop_with_error("request raised while in reset");
			held <= 1'b0;
		end else begin
			if (held) begin
				assert (mem_req_valid) else stop_with_error("request dropped before ready");
				assert (mem_addr == h_addr) else report_value("mem_addr", h_addr, mem_addr);
				assert (mem_we == h_we) else report_value("mem_we", 32'(h_we), 32'(mem_we));
				assert (mem_wstrb == h_strb)
				else report_value("mem_wstrb", 32'(h_strb), 32'(mem_wstrb));
				assert (mem_wdata === h_wdata) else report_value("mem_wdata", h_wdata, mem_wdata);
			end
			held <= mem_req_valid && !mem_req_ready;
			h_addr <= mem_addr;
			h_we <= mem_we;
			h_strb <= mem_wstrb;
			h_wdata <= mem_wdata;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		stop_with_error("timeout: the core stopped making progress");
	end

	initial begin
		done = 1'b0;
		error_count = 0;
		void'($urandom(32'hbfcb22fe));
		build_program();
		run_iss();
		wait (done);
		if (error_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD_NS = 8,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rstn
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rstn = 1'b1; // released just after an edge
	end

endmodule

`default_nettype wire

// File: hdl/rv_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_macros.svh"

module rv_core (
	input  wire                    clk,
	input  wire                    rstn,
	output logic                   mem_req_valid,
	input  wire                    mem_req_ready,
	output logic [`RV_XLEN-1:0]    mem_addr,
	output logic                   mem_we,
	output logic [`RV_STRB_W-1:0]  mem_wstrb,
	output logic [`RV_XLEN-1:0]    mem_wdata,
	input  wire                    mem_rsp_valid,
	input  wire [`RV_XLEN-1:0]     mem_rdata
);
	logic addr_sel_data, dec_en, alu_en, rf_we, pc_step, instr_load;
	logic load_unsigned, is_load, is_store, is_branch, is_jal, is_jalr, use_imm, illegal;
	logic misaligned;
	logic taken;
	logic [`RV_REG_IDX_W-1:0] rd, rs1, rs2;
	logic [`RV_XLEN-1:0] instr_q, load_q, imm, pc, rs1_data, rs2_data;
	logic [`RV_XLEN-1:0] alu_src2, alu_result, rd_data, word_addr, load_data;
	logic [`RV_STRB_W-1:0] wstrb;
	rv_isa_pkg::alu_op_t alu_op;
	rv_isa_pkg::wb_sel_t wb_sel;
	rv_isa_pkg::mem_size_t mem_size;

	assign alu_src2 = use_imm ? imm : rs2_data;
	assign taken = |alu_result; // branch compare result
	assign mem_addr = addr_sel_data ? word_addr : {pc[`RV_XLEN-1:2], 2'b00};
	assign mem_wstrb = mem_we ? wstrb : '0;

	always_ff @(posedge clk) begin
		if (instr_load)
			instr_q <= mem_rdata;
		else if (mem_rsp_valid)
			load_q <= load_data; // data response, already lane aligned
	end

	always_comb begin
		case (wb_sel)
			rv_isa_pkg::wb_alu:         rd_data = alu_result;
			rv_isa_pkg::wb_imm:         rd_data = imm;
			rv_isa_pkg::wb_pc_plus_imm: rd_data = pc + imm;
			rv_isa_pkg::wb_pc_plus4:    rd_data = pc + 32'd4;
			rv_isa_pkg::wb_load:        rd_data = load_q;
			default:                    rd_data = '0;
		endcase
	end

	rv_fsm i_fsm (
		.clk(clk), .rstn(rstn), .mem_req_ready(mem_req_ready), .mem_rsp_valid(mem_rsp_valid),
		.mem_req_valid(mem_req_valid), .mem_we(mem_we), .addr_sel_data(addr_sel_data),
		.dec_en(dec_en), .alu_en(alu_en), .rf_we(rf_we), .pc_step(pc_step),
		.instr_load(instr_load), .illegal(illegal), .is_load(is_load), .is_store(is_store),
		.misaligned(misaligned), .wb_sel(wb_sel)
	);

	rv_pc_unit i_pc_unit (
		.clk(clk), .rstn(rstn), .step(pc_step), .is_jal(is_jal), .is_jalr(is_jalr),
		.is_branch(is_branch), .taken(taken), .imm(imm), .rs1_data(rs1_data), .pc(pc)
	);

	rv_decoder i_decoder (
		.clk(clk), .rstn(rstn), .dec_en(dec_en), .instr(instr_q), .rd(rd), .rs1(rs1),
		.rs2(rs2), .imm(imm), .alu_op(alu_op), .wb_sel(wb_sel), .mem_size(mem_size),
		.load_unsigned(load_unsigned), .is_load(is_load), .is_store(is_store),
		.is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr), .use_imm(use_imm),
		.illegal(illegal)
	);

	rv_regfile i_regfile (
		.clk(clk), .rstn(rstn), .rs1_idx(rs1), .rs2_idx(rs2), .rs1_data(rs1_data),
		.rs2_data(rs2_data), .rd_idx(rd), .rd_data(rd_data), .we(rf_we)
	);

	rv_alu i_alu (
		.clk(clk), .rstn(rstn), .en(alu_en), .op(alu_op), .src1(rs1_data), .src2(alu_src2),
		.result(alu_result)
	);

	rv_lsu i_lsu (
		.addr(alu_result), .size(mem_size), .load_unsigned(load_unsigned),
		.store_data(rs2_data), .rdata(mem_rdata), .word_addr(word_addr), .wstrb(wstrb),
		.wdata(mem_wdata), .load_data(load_data), .misaligned(misaligned)
	);

endmodule

`default_nettype wire

// File: hdl/rv_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module rv_fsm (
	input  wire                  clk,
	input  wire                  rstn,
	input  wire                  mem_req_ready,
	input  wire                  mem_rsp_valid,
	output logic                 mem_req_valid,
	output logic                 mem_we,
	output logic                 addr_sel_data,
	output logic                 dec_en,
	output logic                 alu_en,
	output logic                 rf_we,
	output logic                 pc_step,
	output logic                 instr_load,
	input  wire                  illegal,
	input  wire                  is_load,
	input  wire                  is_store,
	input  wire                  misaligned,
	input  rv_isa_pkg::wb_sel_t  wb_sel
);
	rv_ctrl_pkg::core_state_t state;
	rv_ctrl_pkg::core_state_t state_next;
	logic mem_op;
	logic bad_access;

	assign mem_op = is_load || is_store;
	assign bad_access = mem_op && misaligned; // lsu flag only counts for memory ops

	assign mem_req_valid = (state == rv_ctrl_pkg::st_fetch_req)
		|| (state == rv_ctrl_pkg::st_mem_req && !bad_access);
	assign mem_we = state == rv_ctrl_pkg::st_mem_req && is_store && !bad_access;
	assign addr_sel_data = state == rv_ctrl_pkg::st_mem_req;
	assign dec_en = state == rv_ctrl_pkg::st_decode;
	assign alu_en = state == rv_ctrl_pkg::st_exec;
	assign rf_we = state == rv_ctrl_pkg::st_write && wb_sel != rv_isa_pkg::wb_none
		&& !illegal && !bad_access;
	assign pc_step = state == rv_ctrl_pkg::st_write;
	assign instr_load = state == rv_ctrl_pkg::st_fetch_rsp && mem_rsp_valid;

	always_comb begin
		state_next = state;
		case (state)
			rv_ctrl_pkg::st_wait:
				state_next = rv_ctrl_pkg::st_fetch_req;
			rv_ctrl_pkg::st_fetch_req:
				if (mem_req_ready)
					state_next = rv_ctrl_pkg::st_fetch_rsp;
			rv_ctrl_pkg::st_fetch_rsp:
				if (mem_rsp_valid)
					state_next = rv_ctrl_pkg::st_decode;
			rv_ctrl_pkg::st_decode:
				state_next = rv_ctrl_pkg::st_exec;
			rv_ctrl_pkg::st_exec:
				if (!illegal && mem_op)
					state_next = rv_ctrl_pkg::st_mem_req; // address is ready next cycle
				else
					state_next = rv_ctrl_pkg::st_write;
			rv_ctrl_pkg::st_mem_req:
				if (bad_access)
					state_next = rv_ctrl_pkg::st_write; // skipped, no bus access
				else if (mem_req_ready)
					state_next = rv_ctrl_pkg::st_mem_rsp;
			rv_ctrl_pkg::st_mem_rsp:
				if (mem_rsp_valid)
					state_next = rv_ctrl_pkg::st_write;
			default:
				state_next = rv_ctrl_pkg::st_fetch_req;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn)
			state <= rv_ctrl_pkg::st_wait;
		else
			state <= state_next;
	end

endmodule

`default_nettype wire

// File: hdl/rv_pc_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_macros.svh"

module rv_pc_unit (
	input  wire                  clk,
	input  wire                  rstn,
	input  wire                  step,
	input  wire                  is_jal,
	input  wire                  is_jalr,
	input  wire                  is_branch,
	input  wire                  taken,
	input  wire [`RV_XLEN-1:0]   imm,
	input  wire [`RV_XLEN-1:0]   rs1_data,
	output logic [`RV_XLEN-1:0]  pc
);
	logic [`RV_XLEN-1:0] jalr_target;
	logic [`RV_XLEN-1:0] next_pc;

	assign jalr_target = rs1_data + imm;

	always_comb begin
		if (is_jalr)
			next_pc = {jalr_target[`RV_XLEN-1:1], 1'b0};
		else if (is_jal || (is_branch && taken))
			next_pc = pc + imm;
		else
			next_pc = pc + 32'd4;
	end

	always_ff @(posedge clk) begin
		if (!rstn)
			pc <= `RV_RESET_PC;
		else if (step)
			pc <= next_pc;
	end

endmodule

`default_nettype wire

// File: hdl/rv_lsu.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_macros.svh"

module rv_lsu (
	input  wire [`RV_XLEN-1:0]     addr,
	input  rv_isa_pkg::mem_size_t  size,
	input  wire                    load_unsigned,
	input  wire [`RV_XLEN-1:0]     store_data,
	input  wire [`RV_XLEN-1:0]     rdata,
	output logic [`RV_XLEN-1:0]    word_addr,
	output logic [`RV_STRB_W-1:0]  wstrb,
	output logic [`RV_XLEN-1:0]    wdata,
	output logic [`RV_XLEN-1:0]    load_data,
	output logic                   misaligned
);
	logic [1:0] offset;
	logic [4:0] lane_shift;
	logic [`RV_XLEN-1:0] lane_data;

	assign offset = addr[1:0];
	assign lane_shift = {offset, 3'b000};
	assign word_addr = {addr[`RV_XLEN-1:2], 2'b00};
	assign lane_data = rdata << lane_shift; // addressed byte moves to [31:24]

	always_comb begin
		misaligned = 1'b0;
		wstrb = '0;
		wdata = '0;
		load_data = rdata;
		case (size)
			rv_isa_pkg::size_byte: begin
				wstrb = 4'b1000 >> offset;
				wdata = {store_data[7:0], 24'b0} >> lane_shift;
				if (load_unsigned)
					load_data = {24'b0, lane_data[31:24]};
				else
					load_data = {{24{lane_data[31]}}, lane_data[31:24]};
			end
			rv_isa_pkg::size_half: begin
				misaligned = offset[0];
				wstrb = offset[0] ? 4'b0000 : (4'b1100 >> offset);
				wdata = {store_data[15:0], 16'b0} >> lane_shift;
				if (load_unsigned)
					load_data = {16'b0, lane_data[31:16]};
				else
					load_data = {{16{lane_data[31]}}, lane_data[31:16]};
			end
			default: begin
				misaligned = offset != 2'b00;
				wstrb = misaligned ? 4'b0000 : 4'b1111;
				wdata = store_data;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/rv_alu.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_macros.svh"

module rv_alu (
	input  wire                  clk,
	input  wire                  rstn,
	input  wire                  en,
	input  rv_isa_pkg::alu_op_t  op,
	input  wire [`RV_XLEN-1:0]   src1,
	input  wire [`RV_XLEN-1:0]   src2,
	output logic [`RV_XLEN-1:0]  result
);
	logic [4:0] shamt;
	logic lt_s;
	logic lt_u;
	logic eq;

	assign shamt = src2[4:0];
	assign lt_s = $signed(src1) < $signed(src2);
	assign lt_u = src1 < src2;
	assign eq = src1 == src2;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			result <= '0;
		end else if (en) begin
			case (op)
				rv_isa_pkg::alu_add:  result <= src1 + src2;
				rv_isa_pkg::alu_sub:  result <= src1 - src2;
				rv_isa_pkg::alu_slt,
				rv_isa_pkg::alu_lt:   result <= {{(`RV_XLEN-1){1'b0}}, lt_s};
				rv_isa_pkg::alu_sltu,
				rv_isa_pkg::alu_ltu:  result <= {{(`RV_XLEN-1){1'b0}}, lt_u};
				rv_isa_pkg::alu_xor:  result <= src1 ^ src2;
				rv_isa_pkg::alu_or:   result <= src1 | src2;
				rv_isa_pkg::alu_and:  result <= src1 & src2;
				rv_isa_pkg::alu_sll:  result <= src1 << shamt;
				rv_isa_pkg::alu_srl:  result <= src1 >> shamt;
				rv_isa_pkg::alu_sra:  result <= $signed(src1) >>> shamt;
				rv_isa_pkg::alu_eq:   result <= {{(`RV_XLEN-1){1'b0}}, eq};
				rv_isa_pkg::alu_ne:   result <= {{(`RV_XLEN-1){1'b0}}, !eq};
				rv_isa_pkg::alu_ge:   result <= {{(`RV_XLEN-1){1'b0}}, !lt_s};
				default:              result <= {{(`RV_XLEN-1){1'b0}}, !lt_u}; // geu
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_macros.svh"

module rv_regfile (
	input  wire                      clk,
	input  wire                      rstn,
	input  wire [`RV_REG_IDX_W-1:0]  rs1_idx,
	input  wire [`RV_REG_IDX_W-1:0]  rs2_idx,
	output logic [`RV_XLEN-1:0]      rs1_data,
	output logic [`RV_XLEN-1:0]      rs2_data,
	input  wire [`RV_REG_IDX_W-1:0]  rd_idx,
	input  wire [`RV_XLEN-1:0]       rd_data,
	input  wire                      we
);
	logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

	assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < `RV_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we && rd_idx != '0) begin // x0 stays zero
			regs[rd_idx] <= rd_data;
		end
	end

endmodule

`default_nettype wire

// File: hdl/rv_decoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_macros.svh"

module rv_decoder (
	input  wire                          clk,
	input  wire                          rstn,
	input  wire                          dec_en,
	input  wire [`RV_XLEN-1:0]           instr,
	output logic [`RV_REG_IDX_W-1:0]     rd,
	output logic [`RV_REG_IDX_W-1:0]     rs1,
	output logic [`RV_REG_IDX_W-1:0]     rs2,
	output logic [`RV_XLEN-1:0]          imm,
	output rv_isa_pkg::alu_op_t          alu_op,
	output rv_isa_pkg::wb_sel_t          wb_sel,
	output rv_isa_pkg::mem_size_t        mem_size,
	output logic                         load_unsigned,
	output logic                         is_load,
	output logic                         is_store,
	output logic                         is_branch,
	output logic                         is_jal,
	output logic                         is_jalr,
	output logic                         use_imm,
	output logic                         illegal
);
	rv_isa_pkg::opcode_t opcode;
	rv_isa_pkg::alu_op_t alu_op_d;
	rv_isa_pkg::wb_sel_t wb_sel_d;
	rv_isa_pkg::mem_size_t mem_size_d;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic f7_zero;
	logic f7_alt;
	logic [`RV_XLEN-1:0] imm_d;
	logic is_load_d, is_store_d, is_branch_d, is_jal_d, is_jalr_d, use_imm_d, illegal_d;

	assign opcode = rv_isa_pkg::opcode_t'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign f7_zero = funct7 == 7'b0000000;
	assign f7_alt = funct7 == 7'b0100000;

	always_comb begin
		alu_op_d = rv_isa_pkg::alu_add;
		wb_sel_d = rv_isa_pkg::wb_none;
		mem_size_d = rv_isa_pkg::size_word;
		imm_d = {{20{instr[31]}}, instr[31:20]}; // I format
		is_load_d = 1'b0;
		is_store_d = 1'b0;
		is_branch_d = 1'b0;
		is_jal_d = 1'b0;
		is_jalr_d = 1'b0;
		use_imm_d = 1'b1;
		illegal_d = 1'b0;
		case (opcode)
			rv_isa_pkg::opc_lui, rv_isa_pkg::opc_auipc: begin
				imm_d = {instr[31:12], 12'b0};
				wb_sel_d = (opcode == rv_isa_pkg::opc_lui) ? rv_isa_pkg::wb_imm
					: rv_isa_pkg::wb_pc_plus_imm;
			end
			rv_isa_pkg::opc_jal: begin
				imm_d = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
				wb_sel_d = rv_isa_pkg::wb_pc_plus4;
				is_jal_d = 1'b1;
			end
			rv_isa_pkg::opc_jalr: begin
				wb_sel_d = rv_isa_pkg::wb_pc_plus4;
				is_jalr_d = 1'b1;
				illegal_d = funct3 != 3'b000;
			end
			rv_isa_pkg::opc_branch: begin
				imm_d = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
				is_branch_d = 1'b1;
				use_imm_d = 1'b0;
				case (funct3)
					3'b000: alu_op_d = rv_isa_pkg::alu_eq;
					3'b001: alu_op_d = rv_isa_pkg::alu_ne;
					3'b100: alu_op_d = rv_isa_pkg::alu_lt;
					3'b101: alu_op_d = rv_isa_pkg::alu_ge;
					3'b110: alu_op_d = rv_isa_pkg::alu_ltu;
					3'b111: alu_op_d = rv_isa_pkg::alu_geu;
					default: illegal_d = 1'b1;
				endcase
			end
			rv_isa_pkg::opc_load: begin
				wb_sel_d = rv_isa_pkg::wb_load;
				is_load_d = 1'b1;
				mem_size_d = rv_isa_pkg::mem_size_t'(funct3[1:0]);
				illegal_d = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
			end
			rv_isa_pkg::opc_store: begin
				imm_d = {{20{instr[31]}}, instr[31:25], instr[11:7]};
				is_store_d = 1'b1;
				mem_size_d = rv_isa_pkg::mem_size_t'(funct3[1:0]);
				illegal_d = funct3[2] || (funct3[1:0] == 2'b11);
			end
			rv_isa_pkg::opc_op_imm, rv_isa_pkg::opc_op: begin
				wb_sel_d = rv_isa_pkg::wb_alu;
				use_imm_d = opcode == rv_isa_pkg::opc_op_imm;
				case (funct3)
					3'b000: alu_op_d = (!use_imm_d && funct7[5]) ? rv_isa_pkg::alu_sub
						: rv_isa_pkg::alu_add;
					3'b001: alu_op_d = rv_isa_pkg::alu_sll;
					3'b010: alu_op_d = rv_isa_pkg::alu_slt;
					3'b011: alu_op_d = rv_isa_pkg::alu_sltu;
					3'b100: alu_op_d = rv_isa_pkg::alu_xor;
					3'b101: alu_op_d = funct7[5] ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
					3'b110: alu_op_d = rv_isa_pkg::alu_or;
					default: alu_op_d = rv_isa_pkg::alu_and;
				endcase
				if (!use_imm_d)
					illegal_d = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
				else if (funct3 == 3'b001)
					illegal_d = !f7_zero;
				else if (funct3 == 3'b101)
					illegal_d = !(f7_zero || f7_alt);
			end
			default: illegal_d = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			alu_op <= rv_isa_pkg::alu_add;
			wb_sel <= rv_isa_pkg::wb_none;
			mem_size <= rv_isa_pkg::size_word;
			load_unsigned <= 1'b0;
			is_load <= 1'b0;
			is_store <= 1'b0;
			is_branch <= 1'b0;
			is_jal <= 1'b0;
			is_jalr <= 1'b0;
			use_imm <= 1'b0;
			illegal <= 1'b0;
		end else if (dec_en) begin
			alu_op <= alu_op_d;
			wb_sel <= illegal_d ? rv_isa_pkg::wb_none : wb_sel_d;
			mem_size <= mem_size_d;
			load_unsigned <= funct3[2];
			is_load <= is_load_d && !illegal_d; // an illegal word has no kind
			is_store <= is_store_d && !illegal_d;
			is_branch <= is_branch_d && !illegal_d;
			is_jal <= is_jal_d && !illegal_d;
			is_jalr <= is_jalr_d && !illegal_d;
			use_imm <= use_imm_d;
			illegal <= illegal_d;
		end
	end

	always_ff @(posedge clk) begin
		if (dec_en) begin
			rd <= instr[11:7];
			rs1 <= instr[19:15];
			rs2 <= instr[24:20];
			imm <= imm_d;
		end
	end

endmodule

`default_nettype wire

// File: hdl/rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

	typedef enum logic [2:0] {
		st_wait,
		st_fetch_req,
		st_fetch_rsp,
		st_decode,
		st_exec,
		st_mem_req,
		st_mem_rsp,
		st_write
	} core_state_t;

endpackage

`default_nettype wire

// File: hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011
	} opcode_t;

	// compare ops return 1 or 0
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_slt, alu_sltu,
		alu_xor, alu_or, alu_and, alu_sll,
		alu_srl, alu_sra, alu_eq, alu_ne,
		alu_lt, alu_ge, alu_ltu, alu_geu
	} alu_op_t;

	typedef enum logic [1:0] {
		size_byte = 2'b00,
		size_half = 2'b01,
		size_word = 2'b10
	} mem_size_t;

	typedef enum logic [2:0] {
		wb_none, wb_alu, wb_imm, wb_pc_plus_imm, wb_pc_plus4, wb_load
	} wb_sel_t;

endpackage

`default_nettype wire

// File: hdl/rv_core_macros.svh
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// data and address width
`define RV_XLEN 32

// register index width and count
`define RV_REG_IDX_W 5
`define RV_NUM_REGS 32

`define RV_RESET_PC 32'h0000_0000

// one strobe per byte lane
`define RV_STRB_W 4

`endif
